/* verilog/conv_pkg.sv */
// Convolution engine shared types
`default_nettype none

package conv_pkg;

    // Fixed-point format and window geometry
    localparam int WEIGHT_Q_SHIFT = 6;
    localparam int KERNEL_SIZE = 3;

    typedef logic [7:0] pixel_t;
    // Unsigned Q2.6
    typedef logic [7:0] weight_t;
    typedef logic [3:0] weight_idx_t;
    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Indexed [ky][kx], row 0 is the oldest
    typedef pixel_t [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] window_t;
    typedef weight_t [KERNEL_SIZE-1:0][KERNEL_SIZE-1:0] weights_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } pixel_stream_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        S_GET_ROW,
        S_CALC_WAIT,
        S_CALC,
        S_WAIT_READ
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/weight_regs.sv */
// APB kernel weight registers
`default_nettype none

module weight_regs (
    input  logic               clock_i,
    input  logic               reset_i,
    input  conv_pkg::apb_req_t apb_i,
    output conv_pkg::apb_rsp_t apb_o,
    output conv_pkg::weights_t weights_o
);
    localparam int NUM_WEIGHTS = conv_pkg::KERNEL_SIZE * conv_pkg::KERNEL_SIZE;

    conv_pkg::weight_t [NUM_WEIGHTS-1:0] weight_q;
    conv_pkg::weight_idx_t               idx;
    logic                                access;
    logic                                addr_ok;

    // One weight per 32-bit word slot
    assign idx = apb_i.paddr[5:2];
    assign addr_ok = (apb_i.paddr[7:6] == 2'b00) && (apb_i.paddr[1:0] == 2'b00)
                     && (idx < conv_pkg::weight_idx_t'(NUM_WEIGHTS));
    assign access = apb_i.psel && apb_i.penable;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            weight_q <= '0;
        end else if (access && apb_i.pwrite && addr_ok) begin
            weight_q[idx] <= apb_i.pwdata[7:0];
        end
    end

    // Zero wait states, bad addresses flagged in the access phase
    always_comb begin
        apb_o.pready = access;
        apb_o.pslverr = access && !addr_ok;
        apb_o.prdata = '0;
        if (access && !apb_i.pwrite && addr_ok) begin
            apb_o.prdata = conv_pkg::apb_data_t'(weight_q[idx]);
        end
    end

    // Register ky*3+kx lands at [ky][kx]
    always_comb begin
        for (int ky = 0; ky < conv_pkg::KERNEL_SIZE; ky++) begin
            for (int kx = 0; kx < conv_pkg::KERNEL_SIZE; kx++) begin
                weights_o[ky][kx] = weight_q[ky * conv_pkg::KERNEL_SIZE + kx];
            end
        end
    end
endmodule

`default_nettype wire

/* verilog/row_deserializer.sv */
// Serial pixel to row gatherer
`default_nettype none

module row_deserializer #(
    parameter int IMAGE_WIDTH = 8
) (
    input  logic                               clock_i,
    input  logic                               reset_i,
    input  conv_pkg::pixel_stream_t            pixel_i,
    output logic                               upstream_stall_o,
    output conv_pkg::pixel_t [IMAGE_WIDTH-1:0] row_o,
    output logic                               row_valid_o,
    input  logic                               row_accept_i
);
    localparam int CNT_W = $clog2(IMAGE_WIDTH + 1);

    conv_pkg::pixel_t [IMAGE_WIDTH-1:0] row_q;
    logic [CNT_W-1:0]                   count_q;
    logic                               full;
    logic                               take;

    assign full = (count_q == CNT_W'(IMAGE_WIDTH));
    assign take = pixel_i.valid && !full;

    // First pixel of the row ends up in column 0
    always_ff @(posedge clock_i) begin
        if (take) begin
            row_q <= {pixel_i.data, row_q[IMAGE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (full && row_accept_i) begin
            count_q <= '0;
        end else if (take) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign row_o = row_q;
    assign row_valid_o = full;
    // Hold off the source until the controller takes the row
    assign upstream_stall_o = full;
endmodule

`default_nettype wire

/* verilog/window_buffer.sv */
// Three-row rotating window buffer
`default_nettype none

module window_buffer #(
    parameter int IMAGE_WIDTH = 8
) (
    input  logic                               clock_i,
    input  logic                               reset_i,
    input  conv_pkg::pixel_t [IMAGE_WIDTH-1:0] row_i,
    input  logic                               shift_vert_i,
    input  logic                               shift_horiz_i,
    output conv_pkg::window_t                  window_o
);
    localparam int KSIZE = conv_pkg::KERNEL_SIZE;

    // Row 0 is the oldest, row KSIZE-1 the newest
    conv_pkg::pixel_t [KSIZE-1:0][IMAGE_WIDTH-1:0] rows_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            rows_q <= '0;
        end else if (shift_vert_i) begin
            // Oldest row drops out
            for (int r = 0; r < KSIZE - 1; r++) begin
                rows_q[r] <= rows_q[r+1];
            end
            rows_q[KSIZE-1] <= row_i;
        end else if (shift_horiz_i) begin
            // Rotate left, column 0 wraps to the end
            for (int r = 0; r < KSIZE; r++) begin
                rows_q[r] <= {rows_q[r][0], rows_q[r][IMAGE_WIDTH-1:1]};
            end
        end
    end

    // Window taps are the first KSIZE columns of every row
    always_comb begin
        for (int ky = 0; ky < KSIZE; ky++) begin
            for (int kx = 0; kx < KSIZE; kx++) begin
                window_o[ky][kx] = rows_q[ky][kx];
            end
        end
    end
endmodule

`default_nettype wire

/* verilog/conv_kernel.sv */
// Nine-tap fixed-point MAC
`default_nettype none

module conv_kernel (
    input  logic               clock_i,
    input  conv_pkg::window_t  window_i,
    input  conv_pkg::weights_t weights_i,
    output conv_pkg::pixel_t   result_o
);
    localparam int KSIZE = conv_pkg::KERNEL_SIZE;

    // 16-bit products; nine shifted terms still fit in 16 bits
    logic [KSIZE-1:0][KSIZE-1:0][15:0] term;
    logic [15:0]                       sum;

    always_comb begin
        for (int ky = 0; ky < KSIZE; ky++) begin
            for (int kx = 0; kx < KSIZE; kx++) begin
                term[ky][kx] = (16'(window_i[ky][kx]) * 16'(weights_i[ky][kx]))
                               >> conv_pkg::WEIGHT_Q_SHIFT;
            end
        end
    end

    always_comb begin
        sum = '0;
        for (int ky = 0; ky < KSIZE; ky++) begin
            for (int kx = 0; kx < KSIZE; kx++) begin
                sum = sum + term[ky][kx];
            end
        end
    end

    // Low byte only, result one cycle after the window
    always_ff @(posedge clock_i) begin
        result_o <= sum[7:0];
    end
endmodule

`default_nettype wire

/* verilog/column_counter.sv */
// Row fill and column position counter
`default_nettype none

module column_counter #(
    parameter int IMAGE_WIDTH = 8
) (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  logic                           count_row_i,
    input  logic                           count_col_i,
    input  logic                           clear_col_i,
    output logic                           rows_full_o,
    output logic                           last_col_o,
    output logic [$clog2(IMAGE_WIDTH)-1:0] col_idx_o
);
    localparam int KSIZE = conv_pkg::KERNEL_SIZE;
    localparam int ROW_W = $clog2(KSIZE + 1);
    localparam int COL_W = $clog2(IMAGE_WIDTH);

    logic [ROW_W-1:0] rows_q;
    logic [COL_W-1:0] col_q;

    // Saturates once the window holds KSIZE rows
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            rows_q <= '0;
        end else if (count_row_i && rows_q != ROW_W'(KSIZE)) begin
            rows_q <= rows_q + 1'b1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i || clear_col_i) begin
            col_q <= '0;
        end else if (count_col_i) begin
            col_q <= last_col_o ? '0 : col_q + 1'b1;
        end
    end

    // Counts the row being taken this cycle as well
    assign rows_full_o = (rows_q == ROW_W'(KSIZE))
                         || (count_row_i && rows_q == ROW_W'(KSIZE - 1));
    assign last_col_o = (col_q == COL_W'(IMAGE_WIDTH - 1));
    assign col_idx_o = col_q;
endmodule

`default_nettype wire

/* verilog/row_controller.sv */
// Row sequencing FSM
`default_nettype none

module row_controller (
    input  logic clock_i,
    input  logic reset_i,
    input  logic row_valid_i,
    output logic row_accept_o,
    output logic shift_vert_o,
    output logic shift_horiz_o,
    output logic count_row_o,
    output logic count_col_o,
    output logic clear_col_o,
    input  logic rows_full_i,
    input  logic last_col_i,
    output logic pixel_write_o,
    output logic row_load_o,
    input  logic serializer_busy_i
);
    conv_pkg::ctrl_state_t state_q;
    conv_pkg::ctrl_state_t next_state;

    always_comb begin
        next_state = state_q;
        row_accept_o = 1'b0;
        shift_vert_o = 1'b0;
        shift_horiz_o = 1'b0;
        count_row_o = 1'b0;
        count_col_o = 1'b0;
        clear_col_o = 1'b0;
        pixel_write_o = 1'b0;
        row_load_o = 1'b0;
        case (state_q)
            conv_pkg::S_GET_ROW: begin
                if (row_valid_i) begin
                    row_accept_o = 1'b1;
                    shift_vert_o = 1'b1;
                    count_row_o = 1'b1;
                    // Start computing once the window is complete
                    if (rows_full_i) begin
                        clear_col_o = 1'b1;
                        next_state = conv_pkg::S_CALC_WAIT;
                    end
                end
            end
            conv_pkg::S_CALC_WAIT: begin
                // Kernel register catches up with the buffer
                next_state = conv_pkg::S_CALC;
            end
            conv_pkg::S_CALC: begin
                pixel_write_o = 1'b1;
                shift_horiz_o = 1'b1;
                count_col_o = 1'b1;
                next_state = last_col_i ? conv_pkg::S_WAIT_READ : conv_pkg::S_CALC_WAIT;
            end
            conv_pkg::S_WAIT_READ: begin
                // Previous row must finish streaming out
                if (!serializer_busy_i) begin
                    row_load_o = 1'b1;
                    next_state = conv_pkg::S_GET_ROW;
                end
            end
            default: begin
                next_state = conv_pkg::S_GET_ROW;
            end
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= conv_pkg::S_GET_ROW;
        end else begin
            state_q <= next_state;
        end
    end
endmodule

`default_nettype wire

/* verilog/row_serializer.sv */
// Output row to serial pixel stream
`default_nettype none

module row_serializer #(
    parameter int IMAGE_WIDTH = 8
) (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  logic                           pixel_write_i,
    input  logic [$clog2(IMAGE_WIDTH)-1:0] col_idx_i,
    input  conv_pkg::pixel_t               result_i,
    input  logic                           row_load_i,
    output logic                           busy_o,
    output conv_pkg::pixel_stream_t        pixel_o,
    input  logic                           downstream_stall_i
);
    localparam int CNT_W = $clog2(IMAGE_WIDTH + 1);

    conv_pkg::pixel_t [IMAGE_WIDTH-1:0] row_q;
    conv_pkg::pixel_t [IMAGE_WIDTH-1:0] shift_q;
    logic [CNT_W-1:0]                   left_q;
    logic                               send;

    assign send = busy_o && !downstream_stall_i;

    // Row under construction, filled column by column
    always_ff @(posedge clock_i) begin
        if (pixel_write_i) begin
            row_q[col_idx_i] <= result_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (row_load_i) begin
            shift_q <= row_q;
        end else if (send) begin
            shift_q <= {shift_q[0], shift_q[IMAGE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            left_q <= '0;
        end else if (row_load_i) begin
            left_q <= CNT_W'(IMAGE_WIDTH);
        end else if (send) begin
            left_q <= left_q - 1'b1;
        end
    end

    // Busy until the last pixel has been taken
    assign busy_o = (left_q != '0);
    assign pixel_o.valid = busy_o;
    assign pixel_o.data = shift_q[0];
endmodule

`default_nettype wire

/* verilog/conv_top.sv */
// 3x3 convolution engine top
`default_nettype none

module conv_top #(
    parameter int IMAGE_WIDTH = 8
) (
    input  logic                    clock_i,
    input  logic                    reset_i,
    input  conv_pkg::pixel_stream_t in_pixel_i,
    output logic                    upstream_stall_o,
    output conv_pkg::pixel_stream_t out_pixel_o,
    input  logic                    downstream_stall_i,
    input  conv_pkg::apb_req_t      apb_i,
    output conv_pkg::apb_rsp_t      apb_o
);
    localparam int COL_W = $clog2(IMAGE_WIDTH);

    conv_pkg::weights_t                 weights;
    conv_pkg::pixel_t [IMAGE_WIDTH-1:0] in_row;
    conv_pkg::window_t                  window;
    conv_pkg::pixel_t                   result;
    logic                               row_valid;
    logic                               row_accept;
    logic                               shift_vert;
    logic                               shift_horiz;
    logic                               count_row;
    logic                               count_col;
    logic                               clear_col;
    logic                               rows_full;
    logic                               last_col;
    logic [COL_W-1:0]                   col_idx;
    logic                               pixel_write;
    logic                               row_load;
    logic                               serializer_busy;

    weight_regs weights0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .apb_i(apb_i), .apb_o(apb_o), .weights_o(weights)
    );

    row_deserializer #(.IMAGE_WIDTH(IMAGE_WIDTH)) deser0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .pixel_i(in_pixel_i), .upstream_stall_o(upstream_stall_o),
        .row_o(in_row), .row_valid_o(row_valid), .row_accept_i(row_accept)
    );

    window_buffer #(.IMAGE_WIDTH(IMAGE_WIDTH)) buffer0 (
        .clock_i(clock_i), .reset_i(reset_i), .row_i(in_row),
        .shift_vert_i(shift_vert), .shift_horiz_i(shift_horiz), .window_o(window)
    );

    conv_kernel kernel0 (
        .clock_i(clock_i), .window_i(window), .weights_i(weights), .result_o(result)
    );

    column_counter #(.IMAGE_WIDTH(IMAGE_WIDTH)) counter0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .count_row_i(count_row), .count_col_i(count_col), .clear_col_i(clear_col),
        .rows_full_o(rows_full), .last_col_o(last_col), .col_idx_o(col_idx)
    );

    row_controller ctrl0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .row_valid_i(row_valid), .row_accept_o(row_accept),
        .shift_vert_o(shift_vert), .shift_horiz_o(shift_horiz),
        .count_row_o(count_row), .count_col_o(count_col), .clear_col_o(clear_col),
        .rows_full_i(rows_full), .last_col_i(last_col),
        .pixel_write_o(pixel_write), .row_load_o(row_load),
        .serializer_busy_i(serializer_busy)
    );

    row_serializer #(.IMAGE_WIDTH(IMAGE_WIDTH)) ser0 (
        .clock_i(clock_i), .reset_i(reset_i),
        .pixel_write_i(pixel_write), .col_idx_i(col_idx), .result_i(result),
        .row_load_i(row_load), .busy_o(serializer_busy),
        .pixel_o(out_pixel_o), .downstream_stall_i(downstream_stall_i)
    );
endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Testbench clock and reset
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clock_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2) clock_o = ~clock_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        reset_o <= 1'b0;
    end
endmodule

`default_nettype wire

/* verification/conv_asserts.sv */
// Convolution engine protocol checks
`default_nettype none

module conv_asserts (
    input logic                    clock_i,
    input logic                    reset_i,
    input conv_pkg::pixel_stream_t out_pixel_o,
    input logic                    downstream_stall_i,
    input logic                    upstream_stall_o,
    input conv_pkg::apb_req_t      apb_i,
    input conv_pkg::apb_rsp_t      apb_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // A stalled output pixel must wait unchanged
    out_hold: assert property (@(posedge clock_i) disable iff (reset_i)
        out_pixel_o.valid && downstream_stall_i |=> out_pixel_o.valid
                                                    && $stable(out_pixel_o.data))
    else $error("output pixel changed while the downstream side stalled");

    slverr_in_access: assert property (@(posedge clock_i)
        apb_o.pslverr |-> apb_i.psel && apb_i.penable)
    else $error("APB slave error outside an access phase");

    // Empty deserializer and idle serializer right after reset
    quiet_after_reset: assert property (@(posedge clock_i)
        reset_i |=> !upstream_stall_o && !out_pixel_o.valid)
    else $error("upstream stall or output valid high after reset");
endmodule

bind conv_top conv_asserts asserts0 (
    .clock_i(clock_i), .reset_i(reset_i),
    .out_pixel_o(out_pixel_o), .downstream_stall_i(downstream_stall_i),
    .upstream_stall_o(upstream_stall_o), .apb_i(apb_i), .apb_o(apb_o)
);

`default_nettype wire

/* verification/conv_tb.sv */
// Convolution engine testbench
`default_nettype none

module conv_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMAGE_WIDTH = 8;
    localparam int Q_SHIFT = 6;
    localparam int MAX_ROWS = 12;
    localparam int NUM_CASES = 6;

    typedef enum int {W_IDENTITY, W_BOX, W_RANDOM} weight_mode_t;
    typedef enum int {STALL_NONE, STALL_RANDOM} stall_mode_t;

    typedef struct {
        string        name;
        weight_mode_t weight_mode;
        int           rows;
        stall_mode_t  stall_mode;
        int           exp_pixels;
    } case_t;

    logic                    clock;
    logic                    gen_reset;
    logic                    case_reset;
    conv_pkg::pixel_stream_t in_pixel;
    conv_pkg::pixel_stream_t out_pixel;
    logic                    upstream_stall;
    logic                    downstream_stall = 1'b0;
    conv_pkg::apb_req_t      apb_req;
    conv_pkg::apb_rsp_t      apb_rsp;

    case_t       cases [NUM_CASES];
    logic [7:0]  weights [9];
    logic [7:0]  image [MAX_ROWS][IMAGE_WIDTH];
    logic [7:0]  expected_q [$];
    logic [31:0] lcg_state;
    string       cur_name;
    int          in_count;
    int          out_count;
    int          stall_run;
    int          stall_hold;
    logic        checking;
    logic        stall_enable;
    logic        seen_upstream_stall;
    logic        fail_reported;
    logic        run_passed;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) clock_gen0 (
        .clock_o(clock), .reset_o(gen_reset)
    );

    conv_top #(.IMAGE_WIDTH(IMAGE_WIDTH)) dut0 (
        .clock_i(clock), .reset_i(gen_reset || case_reset),
        .in_pixel_i(in_pixel), .upstream_stall_o(upstream_stall),
        .out_pixel_o(out_pixel), .downstream_stall_i(downstream_stall),
        .apb_i(apb_req), .apb_o(apb_rsp)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_state[31:16]};
    endfunction

    // Nine shifted products, columns wrap around the row
    function automatic logic [7:0] ref_pixel(input int r, input int c);
        logic [15:0] acc;
        acc = '0;
        for (int ky = 0; ky < 3; ky++) begin
            for (int kx = 0; kx < 3; kx++) begin
                acc = acc + ((16'(image[r + ky][(c + kx) % IMAGE_WIDTH])
                              * 16'(weights[ky * 3 + kx])) >> Q_SHIFT);
            end
        end
        return acc[7:0];
    endfunction

    task automatic stop_on_error(input string text);
        fail_reported = 1'b1;
        $display("%s", text);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                                cur_name, what, expected, actual));
    endtask

    task automatic check_output(input logic [7:0] actual);
        logic [7:0] expected;
        assert (in_count >= 3 * IMAGE_WIDTH)
        else stop_on_error($sformatf("[%s] output pixel before three input rows", cur_name));
        assert (expected_q.size() > 0)
        else stop_on_error($sformatf("[%s] more output pixels than the image yields", cur_name));
        expected = expected_q.pop_front();
        assert (actual == expected)
        else report_mismatch($sformatf("output pixel %0d", out_count), 32'(expected), 32'(actual));
        out_count++;
    endtask

    // Setup phase, then one access phase with zero wait states
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        @(posedge clock);
        apb_req.psel <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite <= write;
        apb_req.paddr <= addr;
        apb_req.pwdata <= wdata;
        @(posedge clock);
        apb_req.penable <= 1'b1;
        @(negedge clock);
        assert (apb_rsp.pready)
        else stop_on_error($sformatf("[%s] APB pready low in the access phase", cur_name));
        rdata = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clock);
        apb_req.psel <= 1'b0;
        apb_req.penable <= 1'b0;
        apb_req.pwrite <= 1'b0;
    endtask

    task automatic reset_dut();
        // Get a row streaming out and a full input row before the reset hits
        @(posedge clock);
        in_pixel.valid <= 1'b1;
        in_pixel.data <= 8'h5A;
        do begin
            @(negedge clock);
        end while (!(out_pixel.valid && upstream_stall));
        @(posedge clock);
        case_reset <= 1'b1;
        in_pixel <= '0;
        apb_req <= '0;
        repeat (2) @(posedge clock);
        case_reset <= 1'b0;
        @(negedge clock);
        assert (!out_pixel.valid && !upstream_stall)
        else stop_on_error($sformatf("[%s] out valid or upstream stall high after reset",
                                     cur_name));
    endtask

    task automatic make_weights(input weight_mode_t mode);
        for (int k = 0; k < 9; k++) begin
            case (mode)
                W_IDENTITY: weights[k] = (k == 4) ? 8'd64 : 8'd0;
                // Roughly one ninth in Q2.6
                W_BOX: weights[k] = 8'd7;
                default: weights[k] = 8'(lcg_next() % 32'd32);
            endcase
        end
    endtask

    task automatic load_weights();
        logic [31:0] rdata;
        logic        slverr;
        for (int k = 0; k < 9; k++) begin
            // Upper data bits must be ignored
            apb_access(1'b1, 8'(k * 4), {24'hC3A55A, weights[k]}, rdata, slverr);
            assert (!slverr)
            else stop_on_error($sformatf("[%s] write to weight %0d gave pslverr", cur_name, k));
        end
        apb_access(1'b1, 8'h40, 32'h0000_00FF, rdata, slverr);
        assert (slverr)
        else stop_on_error($sformatf("[%s] write to address 0x40 gave no pslverr", cur_name));
        apb_access(1'b0, 8'd36, 32'd0, rdata, slverr);
        assert (slverr)
        else stop_on_error($sformatf("[%s] read of address 36 gave no pslverr", cur_name));
        assert (rdata == 32'd0)
        else report_mismatch("read data at address 36", 32'd0, rdata);
        for (int k = 0; k < 9; k++) begin
            apb_access(1'b0, 8'(k * 4), 32'd0, rdata, slverr);
            assert (!slverr && rdata == {24'd0, weights[k]})
            else report_mismatch($sformatf("weight %0d read back, pslverr %0b", k, slverr),
                                 {24'd0, weights[k]}, rdata);
        end
    endtask

    task automatic build_expected(input int rows, input weight_mode_t mode);
        expected_q.delete();
        for (int r = 0; r + 2 < rows; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                // Unity centre tap passes the middle row through, one column ahead
                if (mode == W_IDENTITY) begin
                    expected_q.push_back(image[r + 1][(c + 1) % IMAGE_WIDTH]);
                end else begin
                    expected_q.push_back(ref_pixel(r, c));
                end
            end
        end
    endtask

    task automatic send_image(input int rows);
        int   idx;
        int   total;
        logic taken;
        idx = 0;
        total = rows * IMAGE_WIDTH;
        in_pixel.valid <= 1'b1;
        in_pixel.data <= image[0][0];
        while (idx < total) begin
            @(negedge clock);
            taken = !upstream_stall;
            @(posedge clock);
            if (taken) begin
                idx++;
                if (idx < total) begin
                    in_pixel.data <= image[idx / IMAGE_WIDTH][idx % IMAGE_WIDTH];
                end else begin
                    in_pixel.valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic run_case(input case_t tc);
        cur_name = tc.name;
        reset_dut();
        make_weights(tc.weight_mode);
        load_weights();
        for (int r = 0; r < tc.rows; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                image[r][c] = 8'(lcg_next());
            end
        end
        build_expected(tc.rows, tc.weight_mode);
        in_count = 0;
        out_count = 0;
        seen_upstream_stall = 1'b0;
        stall_run = 0;
        stall_hold = 4 * IMAGE_WIDTH;
        checking = 1'b1;
        stall_enable <= (tc.stall_mode == STALL_RANDOM);
        send_image(tc.rows);
        while (expected_q.size() != 0) begin
            @(posedge clock);
        end
        stall_enable <= 1'b0;
        // Quiet window where a surplus pixel would show up
        repeat (4 * IMAGE_WIDTH) @(posedge clock);
        checking = 1'b0;
        assert (out_count == tc.exp_pixels)
        else report_mismatch("output pixel count", 32'(tc.exp_pixels), 32'(out_count));
        assert (tc.stall_mode == STALL_NONE || seen_upstream_stall)
        else stop_on_error($sformatf("[%s] a long output stall never held off the input",
                                     cur_name));
    endtask

    // Transfers are decided here and commit on the next rising edge
    always @(negedge clock) begin
        if (checking) begin
            // Input held off longer than a row's compute time means output back-pressure
            if (upstream_stall) begin
                stall_run++;
                if (stall_run > 2 * IMAGE_WIDTH) begin
                    seen_upstream_stall = 1'b1;
                end
            end else begin
                stall_run = 0;
            end
            if (in_pixel.valid && !upstream_stall) begin
                in_count++;
            end
            if (out_pixel.valid && !downstream_stall) begin
                check_output(out_pixel.data);
            end
        end
    end

    // First output row held back for a while, then about one stalled cycle in three
    always @(posedge clock) begin
        if (!stall_enable) begin
            downstream_stall <= 1'b0;
        end else if (stall_hold > 0) begin
            downstream_stall <= 1'b1;
            if (out_pixel.valid) begin
                stall_hold--;
            end
        end else begin
            downstream_stall <= (lcg_next() % 32'd3) == 32'd0;
        end
    end

    initial begin
        int limit_cycles;
        #1;
        limit_cycles = 1000;
        for (int i = 0; i < NUM_CASES; i++) begin
            limit_cycles += 100 * cases[i].rows * IMAGE_WIDTH;
        end
        repeat (limit_cycles) @(posedge clock);
        stop_on_error("Simulation timed out before all test cases finished");
    end

    initial begin
        in_pixel <= '0;
        apb_req <= '0;
        case_reset <= 1'b0;
        stall_enable <= 1'b0;
        checking = 1'b0;
        fail_reported = 1'b0;
        run_passed = 1'b0;
        lcg_state = 32'd35;
        cases[0] = '{"identity_8rows", W_IDENTITY, 8, STALL_NONE, 48};
        cases[1] = '{"box_5rows", W_BOX, 5, STALL_NONE, 24};
        cases[2] = '{"random_6rows", W_RANDOM, 6, STALL_NONE, 32};
        cases[3] = '{"random_stall", W_RANDOM, 10, STALL_RANDOM, 64};
        cases[4] = '{"two_rows", W_IDENTITY, 2, STALL_NONE, 0};
        cases[5] = '{"identity_stall", W_IDENTITY, 6, STALL_RANDOM, 32};
        wait (gen_reset == 1'b0);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(cases[i]);
        end
        run_passed = 1'b1;
        $display("sim passed");
        $finish;
    end

    final begin
        if (!run_passed && !fail_reported) begin
            $display("sim failed");
        end
    end
endmodule

`default_nettype wire

/* src.f */
verilog/conv_pkg.sv
verilog/weight_regs.sv
verilog/row_deserializer.sv
verilog/window_buffer.sv
verilog/conv_kernel.sv
verilog/column_counter.sv
verilog/row_controller.sv
verilog/row_serializer.sv
verilog/conv_top.sv
verification/tb_clock_gen.sv
verification/conv_asserts.sv
verification/conv_tb.sv

/* Makefile */
SOURCES := $(wildcard verilog/*.sv verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vconv_tb: src.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module conv_tb \
		-f src.f -Mdir obj_dir -o Vconv_tb

run: obj_dir/Vconv_tb
	@out="$$(./obj_dir/Vconv_tb)"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir
